// File: verilog/isa_pkg.sv
`default_nettype none

package isa_pkg;

	localparam int XLEN  = 32;	// operand and address width
	localparam int TAG_W = 5;	// destination tag width

	// load funct3 encodings
	typedef enum logic [2:0] {
		LB  = 3'b000,
		LH  = 3'b001,
		LW  = 3'b010,
		LBU = 3'b100,
		LHU = 3'b101
	} load_op_e;

endpackage

`default_nettype wire

// File: verilog/mem_pkg.sv
`default_nettype none

package mem_pkg;

	// command from the load unit to the data cache
	typedef enum logic [1:0] {
		BUS_NONE = 2'b00,
		BUS_LOAD = 2'b01
	} bus_cmd_e;

	localparam int BLOCK_BYTES = 8;
	localparam int BLOCK_W     = 8 * BLOCK_BYTES;	// 64-bit block

	localparam int LINES    = 32;
	localparam int OFFSET_W = $clog2(BLOCK_BYTES);	// addr[2:0]
	localparam int INDEX_W  = $clog2(LINES);	// addr[7:3]
	localparam int TAG_BITS = 32 - INDEX_W - OFFSET_W;	// addr[31:8]

	localparam int MEM_BLOCKS  = 512;	// 4 KiB backing store
	localparam int MEM_LATENCY = 4;	// request to response, in cycles

endpackage

`default_nettype wire

// File: verilog/load_unit.sv
`timescale 1ns/1ps
`default_nettype none

module load_unit (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      start,
	input  logic [isa_pkg::XLEN-1:0]  opa,
	input  logic [isa_pkg::XLEN-1:0]  opb,
	input  isa_pkg::load_op_e         op,
	input  logic [isa_pkg::TAG_W-1:0] dest_tag,
	input  logic                      finish,
	output mem_pkg::bus_cmd_e         dcache_cmd,
	output logic [isa_pkg::XLEN-1:0]  dcache_addr,
	output isa_pkg::load_op_e         hold_op,
	output logic [isa_pkg::TAG_W-1:0] hold_tag,
	output logic                      busy,
	output logic                      done
);
	import isa_pkg::*;
	import mem_pkg::*;

	logic [XLEN-1:0]  eff_addr;
	logic [XLEN-1:0]  addr_q;	// held effective address
	load_op_e         op_q;
	logic [TAG_W-1:0] tag_q;
	logic             active;
	logic             next_busy;

	assign eff_addr = opa + opb;
	assign active   = start || busy;	// a load is in flight this cycle

	// finish only counts while a load is held
	assign done = finish && active;

	// a hit in the start cycle finishes without ever setting busy
	assign next_busy = active && !done;

	// start cycle passes the new request straight through
	always_comb begin
		if (start) begin
			dcache_addr = eff_addr;
			hold_op     = op;
			hold_tag    = dest_tag;
		end
		else begin
			dcache_addr = addr_q;
			hold_op     = op_q;
			hold_tag    = tag_q;
		end
		dcache_cmd = active ? BUS_LOAD : BUS_NONE;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
		end
		else begin
			busy <= next_busy;
		end
	end

	// request payload, captured once per load
	always_ff @(posedge clock) begin
		if (start) begin
			addr_q <= eff_addr;
			op_q   <= op;
			tag_q  <= dest_tag;
		end
	end

endmodule

`default_nettype wire

// File: verilog/load_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module load_dcache (
	input  logic                        clock,
	input  logic                        reset,
	input  mem_pkg::bus_cmd_e           dcache_cmd,
	input  logic [isa_pkg::XLEN-1:0]    dcache_addr,
	output logic                        finish,
	output logic [mem_pkg::BLOCK_W-1:0] block_data,
	output logic                        mem_req,
	output logic [isa_pkg::XLEN-1:0]    mem_addr,
	input  logic                        mem_valid,
	input  logic [mem_pkg::BLOCK_W-1:0] mem_data
);
	import isa_pkg::*;
	import mem_pkg::*;

	typedef enum logic {
		IDLE,
		MISS_WAIT
	} state_e;

	state_e state;
	state_e next_state;

	logic [TAG_BITS-1:0] tag_array  [LINES];
	logic [BLOCK_W-1:0]  data_array [LINES];
	logic [LINES-1:0]    valid;

	logic [INDEX_W-1:0]  index;
	logic [TAG_BITS-1:0] tag;
	logic [INDEX_W-1:0]  fill_index;	// line being refilled
	logic [TAG_BITS-1:0] fill_tag;
	logic                lookup;
	logic                hit;
	logic                miss;
	logic                fill;

	assign index  = dcache_addr[OFFSET_W +: INDEX_W];
	assign tag    = dcache_addr[XLEN-1 -: TAG_BITS];
	assign lookup = (dcache_cmd == BUS_LOAD);
	assign hit    = valid[index] && (tag_array[index] == tag);

	// lookups are only answered from IDLE, one miss at a time
	assign miss   = lookup && !hit && (state == IDLE);
	assign finish = lookup && hit && (state == IDLE);
	assign fill   = (state == MISS_WAIT) && mem_valid;

	assign block_data = data_array[index];

	// block-aligned fetch, issued in the same cycle as the miss
	assign mem_req  = miss;
	assign mem_addr = {dcache_addr[XLEN-1:OFFSET_W], {OFFSET_W{1'b0}}};

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (miss) begin
					next_state = MISS_WAIT;
				end
			end
			MISS_WAIT: begin
				if (mem_valid) begin
					next_state = IDLE;	// held cmd hits next cycle
				end
			end
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			valid <= '0;
		end
		else begin
			state <= next_state;
			if (fill) begin
				valid[fill_index] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (miss) begin
			fill_index <= index;
			fill_tag   <= tag;
		end
		if (fill) begin
			tag_array[fill_index]  <= fill_tag;
			data_array[fill_index] <= mem_data;
		end
	end

endmodule

`default_nettype wire

// File: verilog/data_memory.sv
`timescale 1ns/1ps
`default_nettype none

module data_memory (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        mem_req,
	input  logic [isa_pkg::XLEN-1:0]    mem_addr,
	output logic                        mem_valid,
	output logic [mem_pkg::BLOCK_W-1:0] mem_data
);
	import mem_pkg::*;

	localparam int MEM_IDX_W = $clog2(MEM_BLOCKS);	// addr[11:3]
	localparam int CNT_W     = $clog2(MEM_LATENCY + 1);

	logic [BLOCK_W-1:0]   mem [MEM_BLOCKS];
	logic [MEM_IDX_W-1:0] req_index;
	logic [CNT_W-1:0]     count;	// cycles left until response
	logic                 pending;

	// byte a holds 7*a + 3, truncated
	initial begin
		for (int b = 0; b < MEM_BLOCKS; b++) begin
			for (int k = 0; k < BLOCK_BYTES; k++) begin
				mem[b][8*k +: 8] = 8'(7 * (b * BLOCK_BYTES + k) + 3);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pending <= 1'b0;
			count   <= '0;
		end
		else if (mem_req) begin
			pending <= 1'b1;
			count   <= CNT_W'(MEM_LATENCY - 1);
		end
		else if (pending) begin
			if (count == '0) begin
				pending <= 1'b0;	// response given this cycle
			end
			else begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (mem_req) begin
			req_index <= mem_addr[OFFSET_W +: MEM_IDX_W];
		end
	end

	assign mem_valid = pending && (count == '0);
	assign mem_data  = mem[req_index];

endmodule

`default_nettype wire

// File: verilog/load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align (
	input  logic [mem_pkg::BLOCK_W-1:0]  block_data,
	input  logic [mem_pkg::OFFSET_W-1:0] byte_offset,
	input  isa_pkg::load_op_e            op,
	output logic [isa_pkg::XLEN-1:0]     result
);
	import isa_pkg::*;
	import mem_pkg::*;

	logic [BLOCK_W-1:0] shifted;

	// addressed byte moved down to bit 0
	assign shifted = block_data >> {byte_offset, 3'b000};

	always_comb begin
		case (op)
			LB: begin
				result = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
			end
			LH: begin
				result = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
			end
			LBU: begin
				result = {{(XLEN-8){1'b0}}, shifted[7:0]};
			end
			LHU: begin
				result = {{(XLEN-16){1'b0}}, shifted[15:0]};
			end
			default: begin
				result = shifted[XLEN-1:0];	// LW
			end
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/load_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module load_subsystem (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      start,
	input  logic [isa_pkg::XLEN-1:0]  opa,
	input  logic [isa_pkg::XLEN-1:0]  opb,
	input  isa_pkg::load_op_e         op,
	input  logic [isa_pkg::TAG_W-1:0] dest_tag,
	output logic                      ready,
	output logic                      done,
	output logic [isa_pkg::XLEN-1:0]  result,
	output logic [isa_pkg::TAG_W-1:0] result_tag
);
	import isa_pkg::*;
	import mem_pkg::*;

	bus_cmd_e           dcache_cmd;
	logic [XLEN-1:0]    dcache_addr;
	logic               finish;
	logic [BLOCK_W-1:0] block_data;
	logic               mem_req;
	logic [XLEN-1:0]    mem_addr;
	logic               mem_valid;
	logic [BLOCK_W-1:0] mem_data;
	load_op_e           hold_op;
	logic               busy;

	assign ready = !busy;

	load_unit load_unit_inst (
		.clock       (clock),
		.reset       (reset),
		.start       (start),
		.opa         (opa),
		.opb         (opb),
		.op          (op),
		.dest_tag    (dest_tag),
		.finish      (finish),
		.dcache_cmd  (dcache_cmd),
		.dcache_addr (dcache_addr),
		.hold_op     (hold_op),
		.hold_tag    (result_tag),
		.busy        (busy),
		.done        (done)
	);

	load_dcache load_dcache_inst (
		.clock       (clock),
		.reset       (reset),
		.dcache_cmd  (dcache_cmd),
		.dcache_addr (dcache_addr),
		.finish      (finish),
		.block_data  (block_data),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.mem_valid   (mem_valid),
		.mem_data    (mem_data)
	);

	data_memory data_memory_inst (
		.clock     (clock),
		.reset     (reset),
		.mem_req   (mem_req),
		.mem_addr  (mem_addr),
		.mem_valid (mem_valid),
		.mem_data  (mem_data)
	);

	// offset comes from the held address, valid alongside done
	load_align load_align_inst (
		.block_data  (block_data),
		.byte_offset (dcache_addr[OFFSET_W-1:0]),
		.op          (hold_op),
		.result      (result)
	);

endmodule

`default_nettype wire

// File: tests/load_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module load_subsystem_tb;
	import isa_pkg::*;
	import mem_pkg::*;

	localparam int CLOCK_PERIOD    = 8;
	localparam int RANDOM_LOADS    = 200;
	localparam int N_LOADS         = 1 + 1 + 26 + 8 + RANDOM_LOADS;
	localparam int LOAD_TIMEOUT    = MEM_LATENCY + 4;	// cycles per load before giving up
	localparam int WATCHDOG_CYCLES = N_LOADS * (MEM_LATENCY + 4) + 200;

	logic             clock;
	logic             reset;
	logic             start;
	logic [XLEN-1:0]  opa;
	logic [XLEN-1:0]  opb;
	load_op_e         op;
	logic [TAG_W-1:0] dest_tag;
	logic             ready;
	logic             done;
	logic [XLEN-1:0]  result;
	logic [TAG_W-1:0] result_tag;

	logic [TAG_W-1:0] exp_tag_q [$];	// scoreboard of the one outstanding load
	logic [XLEN-1:0]  exp_val_q [$];
	logic [TAG_W-1:0] cmp_tag;
	logic [XLEN-1:0]  cmp_val;
	logic [XLEN-1:0]  stim_addr;
	load_op_e         stim_op;
	logic [TAG_W-1:0] tag_ctr;
	int               errors;
	int               checked;
	int               latency;

	load_subsystem load_subsystem_inst (
		.clock      (clock),
		.reset      (reset),
		.start      (start),
		.opa        (opa),
		.opb        (opb),
		.op         (op),
		.dest_tag   (dest_tag),
		.ready      (ready),
		.done       (done),
		.result     (result),
		.result_tag (result_tag)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	// memory pattern followed by RISC-V load extension
	function automatic logic [XLEN-1:0] expected_load(input logic [XLEN-1:0] addr,
			input load_op_e kind);
		int         base;
		logic [7:0] b [4];
		base = int'(addr[11:0]);	// memory ignores upper bits
		for (int k = 0; k < 4; k++) begin
			b[k] = 8'(7 * (base + k) + 3);
		end
		case (kind)
			LB:      return {{24{b[0][7]}}, b[0]};
			LH:      return {{16{b[1][7]}}, b[1], b[0]};
			LBU:     return {24'h000000, b[0]};
			LHU:     return {16'h0000, b[1], b[0]};
			default: return {b[3], b[2], b[1], b[0]};
		endcase
	endfunction

	function automatic load_op_e op_at(input int i);
		case (i)
			0:       return LB;
			1:       return LH;
			2:       return LW;
			3:       return LBU;
			default: return LHU;
		endcase
	endfunction

	function automatic int op_bytes(input load_op_e kind);
		case (kind)
			LW:      return 4;
			LH, LHU: return 2;
			default: return 1;
		endcase
	endfunction

	// entered and left 1 ns after a rising edge
	task automatic issue_load(input logic [XLEN-1:0] addr, input load_op_e kind,
			input logic [TAG_W-1:0] tag, output int cycles);
		logic [XLEN-1:0] split;
		logic            seen;
		while (!ready) begin
			@(posedge clock);
			#1;
		end
		split    = $urandom;
		start    = 1'b1;
		opa      = split;
		opb      = addr - split;	// opa + opb lands on addr
		op       = kind;
		dest_tag = tag;
		exp_tag_q.push_back(tag);
		exp_val_q.push_back(expected_load(addr, kind));
		cycles = 0;
		@(negedge clock);
		seen = done;
		@(posedge clock);
		#1;
		start = 1'b0;
		while (!seen && cycles < LOAD_TIMEOUT) begin
			@(negedge clock);
			cycles++;
			seen = done;
		end
		assert (seen) else begin
			errors++;
			$display("load to address %h with tag %h never finished", addr, tag);
		end
		if (cycles > 0) begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clock);
			#1;
		end
	endtask

	// outputs are settled by the falling edge
	always @(negedge clock) begin
		if (!reset && done) begin
			assert (exp_tag_q.size() != 0) else begin
				errors++;
				$display("done was asserted with no load outstanding");
			end
			if (exp_tag_q.size() != 0) begin
				cmp_tag = exp_tag_q.pop_front();
				cmp_val = exp_val_q.pop_front();
				checked++;
				assert (result == cmp_val) else begin
					errors++;
					$display("FAIL result: got %h expected %h", result, cmp_val);
				end
				assert (result_tag == cmp_tag) else begin
					errors++;
					$display("FAIL result_tag: got %h expected %h", result_tag, cmp_tag);
				end
			end
		end
	end

	initial begin
		void'($urandom(51));
		errors   = 0;
		checked  = 0;
		tag_ctr  = '0;
		reset    = 1'b1;
		start    = 1'b0;
		opa      = '0;
		opb      = '0;
		op       = LB;
		dest_tag = '0;
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;

		assert (ready && !done) else begin
			errors++;
			$display("ready is low or done is high after reset");
		end

		// cold miss followed by a hit in the same block
		issue_load(32'h0000_0124, LW, 5'd1, latency);
		assert (latency != 0) else begin
			errors++;
			$display("first load after reset did not miss");
		end
		issue_load(32'h0000_0126, LH, 5'd2, latency);
		assert (latency == 0) else begin
			errors++;
			$display("hit took %0d cycles instead of finishing with start", latency);
		end

		// block 0x10 mixes bytes above and below 0x80
		for (int k = 0; k < 5; k++) begin
			for (int off = 0; off < BLOCK_BYTES; off++) begin
				stim_op = op_at(k);
				if (off % op_bytes(stim_op) == 0) begin
					issue_load(32'h0000_0010 + XLEN'(off), stim_op, tag_ctr, latency);
					tag_ctr++;
				end
			end
		end

		// same index with different tags
		for (int i = 0; i < 8; i++) begin
			stim_addr = i[0] ? 32'h0000_0148 : 32'h0000_0048;
			issue_load(stim_addr, LW, tag_ctr, latency);
			tag_ctr++;
			assert (latency != 0) else begin
				errors++;
				$display("evicted line at address %h still hit", stim_addr);
			end
		end

		for (int i = 0; i < RANDOM_LOADS; i++) begin
			stim_op   = op_at(int'($urandom_range(4, 0)));
			stim_addr = 32'($urandom_range(1023, 0));
			stim_addr = stim_addr & ~XLEN'(op_bytes(stim_op) - 1);	// natural alignment
			issue_load(stim_addr, stim_op, TAG_W'($urandom), latency);
			idle_cycles(int'($urandom_range(2, 0)));
		end

		idle_cycles(2);
		assert (exp_tag_q.size() == 0) else begin
			errors++;
			$display("%0d loads still outstanding at the end", exp_tag_q.size());
		end
		$display("loads checked: %0d, errors: %0d", checked, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end
		else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("run timed out after %0d cycles, loads checked: %0d, errors: %0d",
			WATCHDOG_CYCLES, checked, errors);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
verilog/isa_pkg.sv
verilog/mem_pkg.sv
verilog/load_unit.sv
verilog/load_dcache.sv
verilog/data_memory.sv
verilog/load_align.sv
verilog/load_subsystem.sv
tests/load_subsystem_tb.sv

// File: Makefile
# Verilator build and run for the load subsystem testbench

VERILATOR ?= verilator
TOP       ?= load_subsystem_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT := Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and look for the pass message in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables (override on the command line):"
	@echo "  VERILATOR=$(VERILATOR) TOP=$(TOP) FILELIST=$(FILELIST)"
	@echo "  BUILD_DIR=$(BUILD_DIR) LOG=$(LOG) VFLAGS='$(VFLAGS)'"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
